// ==== design/umi_fifo_flex.sv ====
// Single clock; change bypass only while idle, fifo_full also rises on chaos-blocked cycles
`timescale 1ns/1ps

module umi_fifo_flex
  #(parameter int IDW   = 256,
    parameter int ODW   = 64,
    parameter int DEPTH = 4
    )
   (input  logic                      umi_in_clk,
    input  logic                      umi_in_nreset,
    // Wide input
    input  logic                      umi_in_valid,
    input  logic [umi_pkg::UMI_CW-1:0] umi_in_cmd,
    input  logic [umi_pkg::UMI_AW-1:0] umi_in_dstaddr,
    input  logic [umi_pkg::UMI_AW-1:0] umi_in_srcaddr,
    input  logic [IDW-1:0]            umi_in_data,
    output logic                      umi_in_ready,
    // Narrow output
    output logic                      umi_out_valid,
    output logic [umi_pkg::UMI_CW-1:0] umi_out_cmd,
    output logic [umi_pkg::UMI_AW-1:0] umi_out_dstaddr,
    output logic [umi_pkg::UMI_AW-1:0] umi_out_srcaddr,
    output logic [ODW-1:0]            umi_out_data,
    input  logic                      umi_out_ready,
    // Register port
    input  logic                      reg_write,
    input  logic [1:0]                reg_addr,
    input  logic [31:0]               reg_wdata,
    output logic [31:0]               reg_rdata,
    // Status
    output logic                      fifo_full,
    output logic                      fifo_empty
    );

   import umi_pkg::*;
   import umi_flex_pkg::*;

   localparam int HW = $bits(umi_hdr_t);
   localparam int DW = HW + ODW;

   logic [1:0]     start_q;
   logic           started;
   flex_ctrl_t     ctrl;
   flex_event_t    events;
   umi_hdr_t       in_hdr;
   umi_hdr_t       piece_hdr;
   umi_hdr_t       fifo_hdr;
   umi_hdr_t       out_hdr;
   logic [ODW-1:0] piece_data;
   logic [ODW-1:0] out_data;
   logic           piece_valid;
   logic           piece_ready;
   logic           split_beat;
   logic           fifo_wr_ready;
   logic           fifo_rd_valid;
   logic [DW-1:0]  fifo_rd_data;

   // Holds both sides quiet for two cycles out of reset
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         start_q <= 2'b00;
      else
         start_q <= {start_q[0], 1'b1};
   end

   assign started = start_q[1];

   always_comb
   begin
      in_hdr.cmd.raw = umi_in_cmd;
      in_hdr.dstaddr = umi_in_dstaddr;
      in_hdr.srcaddr = umi_in_srcaddr;
   end

   //##################################################
   // Splitter and FIFO
   //##################################################

   assign piece_ready = started & (ctrl.bypass ? umi_out_ready : fifo_wr_ready);

   umi_splitter #(.IDW(IDW), .ODW(ODW)) splitter_i
     (.umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .in_valid      (umi_in_valid & started),
      .in_hdr        (in_hdr),
      .in_data       (umi_in_data),
      .in_ready      (umi_in_ready),
      .piece_valid   (piece_valid),
      .piece_hdr     (piece_hdr),
      .piece_data    (piece_data),
      .piece_ready   (piece_ready),
      .split_beat    (split_beat));

   umi_sync_fifo #(.DW(DW), .DEPTH(DEPTH)) fifo_i
     (.umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .chaosmode     (ctrl.chaosmode),
      .wr_valid      (piece_valid & ~ctrl.bypass & started),
      .wr_data       ({piece_data, piece_hdr}),
      .wr_ready      (fifo_wr_ready),
      .rd_valid      (fifo_rd_valid),
      .rd_data       (fifo_rd_data),
      .rd_ready      (umi_out_ready & ~ctrl.bypass & started));

   assign fifo_full  = ~fifo_wr_ready;
   assign fifo_empty = ~fifo_rd_valid;
   assign fifo_hdr   = umi_hdr_t'(fifo_rd_data[HW-1:0]);

   //##################################################
   // Output steering and registers
   //##################################################

   assign out_hdr  = ctrl.bypass ? piece_hdr  : fifo_hdr;
   assign out_data = ctrl.bypass ? piece_data : fifo_rd_data[DW-1:HW];

   assign umi_out_valid   = started & (ctrl.bypass ? piece_valid : fifo_rd_valid);
   assign umi_out_cmd     = out_hdr.cmd.raw;
   assign umi_out_dstaddr = out_hdr.dstaddr;
   assign umi_out_srcaddr = out_hdr.srcaddr;
   assign umi_out_data    = out_data;

   assign events.split_beat = split_beat;
   assign events.out_beat   = umi_out_valid & umi_out_ready;

   umi_flex_regs regs_i
     (.umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .reg_write     (reg_write),
      .reg_addr      (reg_addr),
      .reg_wdata     (reg_wdata),
      .reg_rdata     (reg_rdata),
      .events        (events),
      .ctrl          (ctrl));

endmodule

// ==== design/umi_flex_pkg.sv ====
// Register block types; control word occupies the low bits of a 32-bit register, addresses are 2 bits
package umi_flex_pkg;

   // Register map
   localparam logic [1:0] REG_CTRL   = 2'd0;
   localparam logic [1:0] REG_SPLITS = 2'd1;
   localparam logic [1:0] REG_BEATS  = 2'd2;

   // Control word, bypass in bit 0 and chaos in bit 1
   typedef struct packed
   {
      logic chaosmode;
      logic bypass;
   } flex_ctrl_t;

   // Per-cycle strobes from the datapath
   typedef struct packed
   {
      logic split_beat;
      logic out_beat;
   } flex_event_t;

   // Event counter width
   localparam int CNT_W = 16;

endpackage

// ==== design/umi_flex_regs.sv ====
// Control and status registers; only REG_CTRL holds written data, counters wrap at 16 bits and clear on write
`timescale 1ns/1ps

module umi_flex_regs
   (input  logic                      umi_in_clk,
    input  logic                      umi_in_nreset,
    // Strobe write, combinational read
    input  logic                      reg_write,
    input  logic [1:0]                reg_addr,
    input  logic [31:0]               reg_wdata,
    output logic [31:0]               reg_rdata,
    // Datapath side
    input  umi_flex_pkg::flex_event_t events,
    output umi_flex_pkg::flex_ctrl_t  ctrl
    );

   import umi_flex_pkg::*;

   logic [CNT_W-1:0] split_cnt;
   logic [CNT_W-1:0] beat_cnt;

   //##################################################
   // Registers
   //##################################################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         ctrl      <= '0;
         split_cnt <= '0;
         beat_cnt  <= '0;
      end
      else
      begin
         if (reg_write && (reg_addr == REG_CTRL))
            ctrl <= flex_ctrl_t'(reg_wdata[$bits(flex_ctrl_t)-1:0]);

         // A write wins over a same-cycle event
         if (reg_write && (reg_addr == REG_SPLITS))
            split_cnt <= '0;
         else if (events.split_beat)
            split_cnt <= split_cnt + 1'b1;

         if (reg_write && (reg_addr == REG_BEATS))
            beat_cnt <= '0;
         else if (events.out_beat)
            beat_cnt <= beat_cnt + 1'b1;
      end
   end

   // Read mux
   always_comb
   begin
      case (reg_addr)
         REG_CTRL:   reg_rdata = 32'(ctrl);
         REG_SPLITS: reg_rdata = 32'(split_cnt);
         REG_BEATS:  reg_rdata = 32'(beat_cnt);
         default:    reg_rdata = '0;
      endcase
   end

endmodule

// ==== design/umi_pkg.sv ====
// UMI command and header types; 32-bit command word and 64-bit addresses only, opcode codes beyond atomic are not decoded here
package umi_pkg;

   //##################################################
   // Widths
   //##################################################

   localparam int UMI_CW = 32;
   localparam int UMI_AW = 64;

   // Request opcode whose bits 15..8 carry atype instead of len
   localparam logic [4:0] UMI_REQ_ATOMIC = 5'h09;

   //##################################################
   // Command word views
   //##################################################

   // Read, write and response view
   typedef struct packed
   {
      logic [4:0] hostid;
      logic [1:0] user;
      logic       ex;
      logic       eof;
      logic       eom;
      logic [1:0] prot;
      logic [3:0] qos;
      logic [7:0] len;
      logic [2:0] size;
      logic [4:0] opcode;
   } umi_cmd_rw_t;

   // Atomic view, same bits except 15..8
   typedef struct packed
   {
      logic [4:0] hostid;
      logic [1:0] user;
      logic       ex;
      logic       eof;
      logic       eom;
      logic [1:0] prot;
      logic [3:0] qos;
      logic [7:0] atype;
      logic [2:0] size;
      logic [4:0] opcode;
   } umi_cmd_atomic_t;

   // One command word, decoded by opcode
   typedef union packed
   {
      umi_cmd_rw_t           rw;
      umi_cmd_atomic_t       atomic;
      logic [UMI_CW-1:0]     raw;
   } umi_cmd_u;

   //##################################################
   // Transaction header
   //##################################################

   // Command sits in the low bits when the header is flattened
   typedef struct packed
   {
      logic [UMI_AW-1:0] srcaddr;
      logic [UMI_AW-1:0] dstaddr;
      umi_cmd_u          cmd;
   } umi_hdr_t;

endpackage

// ==== design/umi_splitter.sv ====
// Splits at ODW boundaries only; needs IDW >= ODW, SIZE <= log2(ODW/8) and dstaddr aligned to SIZE
`timescale 1ns/1ps

module umi_splitter
  #(parameter int IDW = 256,
    parameter int ODW = 64
    )
   (input  logic               umi_in_clk,
    input  logic               umi_in_nreset,
    // New transactions
    input  logic               in_valid,
    input  umi_pkg::umi_hdr_t  in_hdr,
    input  logic [IDW-1:0]     in_data,
    output logic               in_ready,
    // Pieces towards FIFO or output
    output logic               piece_valid,
    output umi_pkg::umi_hdr_t  piece_hdr,
    output logic [ODW-1:0]     piece_data,
    input  logic               piece_ready,
    // One pulse per accepted piece that leaves a remainder
    output logic               split_beat
    );

   import umi_pkg::*;

   // Output word in bytes and its address bits
   localparam int W   = ODW / 8;
   localparam int AOW = $clog2(W);
   // Wide enough for (len+1) << size
   localparam int LW  = 20;

   logic              latch_valid;
   umi_hdr_t          latch_hdr;
   logic [IDW-1:0]    latch_data;

   umi_hdr_t          cur_hdr;
   logic [IDW-1:0]    cur_data;
   logic              is_atomic;
   logic [7:0]        eff_len;
   logic [LW-1:0]     offset;
   logic [LW-1:0]     bytes;
   logic [LW-1:0]     step;
   logic [LW-1:0]     step_units;
   logic              need_split;
   logic              accept;
   logic [7:0]        piece_len;
   logic [7:0]        rem_len;
   umi_cmd_u          piece_cmd;
   umi_cmd_u          rem_cmd;

   //##################################################
   // Current transaction
   //##################################################

   // Remainder has priority over new input
   assign cur_hdr  = latch_valid ? latch_hdr  : in_hdr;
   assign cur_data = latch_valid ? latch_data : in_data;

   assign piece_valid = latch_valid | in_valid;
   assign in_ready    = ~latch_valid & piece_ready;
   assign accept      = piece_valid & piece_ready;

   // Atomics move a single element
   assign is_atomic = (cur_hdr.cmd.rw.opcode == UMI_REQ_ATOMIC);
   assign eff_len   = is_atomic ? 8'd0 : cur_hdr.cmd.rw.len;

   //##################################################
   // Split rule
   //##################################################

   assign offset     = LW'(cur_hdr.dstaddr[AOW-1:0]);
   assign bytes      = (LW'(eff_len) + LW'(1)) << cur_hdr.cmd.rw.size;
   assign need_split = (offset + bytes) > LW'(W);

   // Bytes up to the next output-word boundary
   assign step       = LW'(W) - offset;
   assign step_units = step >> cur_hdr.cmd.rw.size;

   assign piece_len = step_units[7:0] - 8'd1;
   assign rem_len   = eff_len - step_units[7:0];

   // Repack command, all other fields kept
   always_comb
   begin
      piece_cmd = cur_hdr.cmd;
      rem_cmd   = cur_hdr.cmd;
      if (need_split)
      begin
         piece_cmd.rw.len = piece_len;
         piece_cmd.rw.eom = 1'b0;
      end
      // atype is not a length, carry it as is
      rem_cmd.rw.len = is_atomic ? cur_hdr.cmd.atomic.atype : rem_len;
   end

   always_comb
   begin
      piece_hdr         = cur_hdr;
      piece_hdr.cmd     = piece_cmd;
   end

   assign piece_data = cur_data[ODW-1:0];
   assign split_beat = accept & need_split;

   //##################################################
   // Remainder latch
   //##################################################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         latch_valid <= 1'b0;
      else if (accept)
         latch_valid <= need_split;
   end

   // Payload only, loads when a remainder is left
   always_ff @(posedge umi_in_clk)
   begin
      if (accept && need_split)
      begin
         latch_hdr.cmd     <= rem_cmd;
         latch_hdr.dstaddr <= cur_hdr.dstaddr + UMI_AW'(step);
         latch_hdr.srcaddr <= cur_hdr.srcaddr + UMI_AW'(step);
         latch_data        <= cur_data >> (step << 3);
      end
   end

endmodule

// ==== design/umi_sync_fifo.sv ====
// Single-clock FIFO, DEPTH must be at least 2; in chaos mode writes are refused on pseudo-random cycles
`timescale 1ns/1ps

module umi_sync_fifo
  #(parameter int DW    = 224,
    parameter int DEPTH = 4
    )
   (input  logic          umi_in_clk,
    input  logic          umi_in_nreset,
    input  logic          chaosmode,
    // Write side
    input  logic          wr_valid,
    input  logic [DW-1:0] wr_data,
    output logic          wr_ready,
    // Read side
    output logic          rd_valid,
    output logic [DW-1:0] rd_data,
    input  logic          rd_ready
    );

   localparam int PW   = $clog2(DEPTH);
   localparam int CNTW = $clog2(DEPTH + 1);

   logic [DW-1:0]   mem [DEPTH];
   logic [PW-1:0]   wr_ptr;
   logic [PW-1:0]   rd_ptr;
   logic [CNTW-1:0] count;
   logic [15:0]     lfsr;
   logic            full;
   logic            wr_en;
   logic            rd_en;

   assign full     = (count == CNTW'(DEPTH));
   assign rd_valid = (count != '0);

   // Chaos blocks the write whenever LFSR bit 0 is low
   assign wr_ready = ~full & (~chaosmode | lfsr[0]);

   assign wr_en   = wr_valid & wr_ready;
   assign rd_en   = rd_valid & rd_ready;
   assign rd_data = mem[rd_ptr];

   //##################################################
   // Pointers and occupancy
   //##################################################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= wr_data;
   end

   // x^16 + x^14 + x^13 + x^11, free running
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         lfsr <= 16'hace1;
      else
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
   end

endmodule

// ==== dv/tb_umi_fifo_flex.sv ====
// Table data assume IDW=256, ODW=64 and DEPTH=4; the three passes run FIFO, FIFO with chaos, then bypass
`timescale 1ns/1ps

module tb_umi_fifo_flex;

   import umi_pkg::*;
   import umi_flex_pkg::*;

   localparam int IDW   = 256;
   localparam int ODW   = 64;
   localparam int DEPTH = 4;
   localparam int NROWS = 7;
   localparam int NPASS = 3;
   // Row whose pieces exactly fill the FIFO
   localparam int FILL_ROW = 2;
   localparam logic [4:0] OPC_WRITE = 5'h03;

   logic           umi_in_clk;
   logic           umi_in_nreset;
   logic           umi_in_valid;
   logic [31:0]    umi_in_cmd;
   logic [63:0]    umi_in_dstaddr;
   logic [63:0]    umi_in_srcaddr;
   logic [IDW-1:0] umi_in_data;
   logic           umi_in_ready;
   logic           umi_out_valid;
   logic [31:0]    umi_out_cmd;
   logic [63:0]    umi_out_dstaddr;
   logic [63:0]    umi_out_srcaddr;
   logic [ODW-1:0] umi_out_data;
   logic           umi_out_ready;
   logic           reg_write;
   logic [1:0]     reg_addr;
   logic [31:0]    reg_wdata;
   logic [31:0]    reg_rdata;
   logic           fifo_full;
   logic           fifo_empty;
   logic           report;
   logic           hold_out;
   logic [31:0]    rng;
   int             tb_errors;
   int             chk_errors;
   int             pending;
   int             exp_pieces;
   int             exp_splits;
   int             cycles;
   int             limit;
   int             nrows;
   int             table_pieces;

   // Stimulus table columns
   logic [63:0] t_dst [NROWS];
   logic [63:0] t_src [NROWS];
   logic [4:0]  t_opc [NROWS];
   logic [2:0]  t_size [NROWS];
   logic [7:0]  t_len [NROWS];
   logic        t_eom [NROWS];
   logic [31:0] t_seed [NROWS];
   int          t_pieces [NROWS];

   umi_fifo_flex #(.IDW(IDW), .ODW(ODW), .DEPTH(DEPTH)) DUT (.*);

   umi_flex_checker #(.IDW(IDW), .ODW(ODW)) chk
     (.umi_in_clk  (umi_in_clk),
      .in_valid    (umi_in_valid),
      .in_ready    (umi_in_ready),
      .in_cmd      (umi_in_cmd),
      .in_dstaddr  (umi_in_dstaddr),
      .in_srcaddr  (umi_in_srcaddr),
      .in_data     (umi_in_data),
      .out_valid   (umi_out_valid),
      .out_ready   (umi_out_ready),
      .out_cmd     (umi_out_cmd),
      .out_dstaddr (umi_out_dstaddr),
      .out_srcaddr (umi_out_srcaddr),
      .out_data    (umi_out_data),
      .report      (report),
      .tb_errors   (tb_errors),
      .errors      (chk_errors),
      .pending     (pending),
      .exp_pieces  (exp_pieces),
      .exp_splits  (exp_splits));

   always #10 umi_in_clk = ~umi_in_clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [IDW-1:0] fill_data(input logic [31:0] seed);
      logic [IDW-1:0] d;
      d = '0;
      for (int i = 0; i < IDW / 32; i++)
         d[32*i +: 32] = seed ^ (32'h01030507 * (i + 1));
      return d;
   endfunction

   // Random back-pressure on the output, held off while filling the FIFO
   always @(posedge umi_in_clk)
   begin
      #1;
      rng = xorshift(rng);
      umi_out_ready = hold_out ? 1'b0 : (rng[1:0] != 2'b00);
   end

   always @(posedge umi_in_clk)
   begin
      cycles++;
      if (limit > 0 && cycles >= limit)
      begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display(">>> FAIL");
         $finish;
      end
   end

   //##################################################
   // Helpers, entered and left 1 ns after a rising edge
   //##################################################

   task automatic add_row(input logic [63:0] dst, input logic [63:0] src, input logic [4:0] opc,
                          input logic [2:0] size, input logic [7:0] len, input logic eom,
                          input logic [31:0] seed, input int pieces);
      t_dst[nrows]    = dst;
      t_src[nrows]    = src;
      t_opc[nrows]    = opc;
      t_size[nrows]   = size;
      t_len[nrows]    = len;
      t_eom[nrows]    = eom;
      t_seed[nrows]   = seed;
      t_pieces[nrows] = pieces;
      table_pieces += pieces;
      nrows++;
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      if (got !== exp)
      begin
         $display("error t=%0t %s exp %0h got %0h", $time, name, exp, got);
         tb_errors++;
      end
   endtask

   task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
      reg_write = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(posedge umi_in_clk);
      #1 reg_write = 1'b0;
   endtask

   task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
      reg_addr = addr;
      @(negedge umi_in_clk);
      data = reg_rdata;
      @(posedge umi_in_clk);
      #1;
   endtask

   task automatic send_row(input int r);
      umi_cmd_u c;
      c.raw          = '0;
      c.rw.opcode    = t_opc[r];
      c.rw.size      = t_size[r];
      c.rw.len       = t_len[r];
      c.rw.eom       = t_eom[r];
      c.rw.qos       = 4'ha;
      c.rw.hostid    = 5'(r + 1);
      umi_in_valid   = 1'b1;
      umi_in_cmd     = c.raw;
      umi_in_dstaddr = t_dst[r];
      umi_in_srcaddr = t_src[r];
      umi_in_data    = fill_data(t_seed[r]);
      @(negedge umi_in_clk);
      while (!(umi_in_valid && umi_in_ready))
         @(negedge umi_in_clk);
      @(posedge umi_in_clk);
      #1 umi_in_valid = 1'b0;
   endtask

   task automatic check_startup();
      int errs_before;
      logic [31:0] rdata;
      errs_before = tb_errors;
      repeat (2)
      begin
         @(negedge umi_in_clk);
         check_value("umi_in_ready", 0, umi_in_ready);
         check_value("umi_out_valid", 0, umi_out_valid);
      end
      @(negedge umi_in_clk);
      check_value("umi_in_ready", 1, umi_in_ready);
      check_value("umi_out_valid", 0, umi_out_valid);
      @(posedge umi_in_clk);
      #1 read_reg(REG_CTRL, rdata);
      check_value("reg_rdata", 0, rdata);
      $display("test startup: %s", (tb_errors == errs_before) ? "ok" : "failed");
   endtask

   task automatic check_fill();
      int errs_before;
      errs_before = tb_errors;
      hold_out = 1'b1;
      // First piece goes in on acceptance, the latch supplies the rest one per cycle
      send_row(FILL_ROW);
      repeat (t_pieces[FILL_ROW] - 1) @(posedge umi_in_clk);
      @(negedge umi_in_clk);
      check_value("fifo_full", 1, fifo_full);
      check_value("fifo_empty", 0, fifo_empty);
      check_value("umi_in_ready", 0, umi_in_ready);
      @(posedge umi_in_clk);
      #1 hold_out = 1'b0;
      while (pending != 0)
         @(posedge umi_in_clk);
      @(negedge umi_in_clk);
      check_value("fifo_full", 0, fifo_full);
      check_value("fifo_empty", 1, fifo_empty);
      @(posedge umi_in_clk);
      #1;
      $display("test fifo fill: %s", (tb_errors == errs_before) ? "ok" : "failed");
   endtask

   task automatic check_counters();
      int errs_before;
      int total_pieces;
      logic [31:0] rdata;
      errs_before  = tb_errors;
      total_pieces = table_pieces * NPASS + t_pieces[FILL_ROW];
      if (exp_pieces != total_pieces)
      begin
         $display("checker expected %0d pieces but the table lists %0d",
                  exp_pieces, total_pieces);
         tb_errors++;
      end
      read_reg(REG_SPLITS, rdata);
      check_value("reg_rdata", 32'(exp_splits[15:0]), rdata);
      read_reg(REG_BEATS, rdata);
      check_value("reg_rdata", 32'(exp_pieces[15:0]), rdata);
      // Any write clears a counter
      write_reg(REG_SPLITS, 32'hffff);
      write_reg(REG_BEATS, 32'hffff);
      read_reg(REG_SPLITS, rdata);
      check_value("reg_rdata", 0, rdata);
      read_reg(REG_BEATS, rdata);
      check_value("reg_rdata", 0, rdata);
      $display("test registers: %s", (tb_errors == errs_before) ? "ok" : "failed");
   endtask

   //##################################################
   // Main sequence
   //##################################################

   initial
   begin
      umi_in_clk     = 1'b0;
      umi_in_nreset  = 1'b0;
      umi_in_valid   = 1'b0;
      umi_in_cmd     = '0;
      umi_in_dstaddr = '0;
      umi_in_srcaddr = '0;
      umi_in_data    = '0;
      umi_out_ready  = 1'b0;
      reg_write      = 1'b0;
      reg_addr       = '0;
      reg_wdata      = '0;
      report         = 1'b0;
      hold_out       = 1'b0;
      rng            = 32'd6;

      // dst, src, opcode, size, len, eom, data seed, pieces
      add_row(64'h1000, 64'h9000, OPC_WRITE,      3'd3, 8'd0,  1'b1, 32'h1111_0001, 1);
      add_row(64'h2000, 64'ha000, OPC_WRITE,      3'd2, 8'd1,  1'b0, 32'h2222_0002, 1);
      add_row(64'h3000, 64'hb000, OPC_WRITE,      3'd3, 8'd3,  1'b1, 32'h3333_0003, 4);
      add_row(64'h4003, 64'hc005, OPC_WRITE,      3'd0, 8'd9,  1'b1, 32'h4444_0004, 2);
      add_row(64'h5004, 64'hd000, OPC_WRITE,      3'd2, 8'd6,  1'b1, 32'h5555_0005, 4);
      add_row(64'h6006, 64'he002, OPC_WRITE,      3'd1, 8'd12, 1'b1, 32'h6666_0006, 4);
      // Atomic, 8'h5a is atype
      add_row(64'h7000, 64'hf000, UMI_REQ_ATOMIC, 3'd3, 8'h5a, 1'b1, 32'h7777_0007, 1);
      limit = 40 * (table_pieces * NPASS + t_pieces[FILL_ROW]) + 200;

      repeat (4) @(posedge umi_in_clk);
      #1 umi_in_nreset = 1'b1;
      check_startup();
      check_fill();

      // FIFO, FIFO with chaos, bypass
      for (int p = 0; p < NPASS; p++)
      begin
         write_reg(REG_CTRL, (p == 1) ? 32'h2 : (p == 2) ? 32'h1 : 32'h0);
         for (int r = 0; r < nrows; r++)
            send_row(r);
         while (pending != 0)
            @(posedge umi_in_clk);
         #1;
      end

      check_counters();
      report = 1'b1;
      #1;
      if (tb_errors == 0 && chk_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== dv/umi_flex_checker.sv ====
// Expects IDW >= ODW and fields no wider than max(ODW, 64); beats are sampled on the falling clock edge
`timescale 1ns/1ps

module umi_flex_checker
  #(parameter int IDW = 256,
    parameter int ODW = 64
    )
   (input  logic           umi_in_clk,
    // DUT input port
    input  logic           in_valid,
    input  logic           in_ready,
    input  logic [31:0]    in_cmd,
    input  logic [63:0]    in_dstaddr,
    input  logic [63:0]    in_srcaddr,
    input  logic [IDW-1:0] in_data,
    // DUT output port
    input  logic           out_valid,
    input  logic           out_ready,
    input  logic [31:0]    out_cmd,
    input  logic [63:0]    out_dstaddr,
    input  logic [63:0]    out_srcaddr,
    input  logic [ODW-1:0] out_data,
    // Closing summary
    input  logic           report,
    input  int             tb_errors,
    output int             errors,
    output int             pending,
    output int             exp_pieces,
    output int             exp_splits
    );

   import umi_pkg::*;

   localparam int W  = ODW / 8;
   localparam int CW = (ODW > 64) ? ODW : 64;

   // Expected pieces in arrival order
   logic [31:0]    q_cmd [$];
   logic [63:0]    q_dst [$];
   logic [63:0]    q_src [$];
   logic [ODW-1:0] q_data [$];
   bit             q_last [$];
   int             tests;
   int             test_errs;
   int             piece_n;

   task automatic push_piece(input logic [31:0] cmd, input logic [63:0] dst,
                             input logic [63:0] src, input logic [ODW-1:0] data, input bit last);
      q_cmd.push_back(cmd);
      q_dst.push_back(dst);
      q_src.push_back(src);
      q_data.push_back(data);
      q_last.push_back(last);
      exp_pieces++;
   endtask

   //##################################################
   // Expected pieces from the boundary rule
   //##################################################

   task automatic expect_txn(input logic [31:0] cmd, input logic [63:0] dst,
                             input logic [63:0] src, input logic [IDW-1:0] data);
      umi_cmd_u c;
      umi_cmd_u pc;
      int       offset;
      int       units;
      int       bytes;
      int       step;
      bit       done;
      c.raw = cmd;
      done  = 1'b0;
      while (!done)
      begin
         offset = int'(dst % W);
         // An atomic moves one element, bits 15..8 are atype
         units  = (c.rw.opcode == UMI_REQ_ATOMIC) ? 1 : int'(c.rw.len) + 1;
         bytes  = units << c.rw.size;
         if (offset + bytes > W)
         begin
            step = W - offset;
            pc = c;
            pc.rw.len = 8'((step >> c.rw.size) - 1);
            pc.rw.eom = 1'b0;
            push_piece(pc.raw, dst, src, data[ODW-1:0], 1'b0);
            exp_splits++;
            c.rw.len = c.rw.len - 8'(step >> c.rw.size);
            dst  = dst + 64'(step);
            src  = src + 64'(step);
            data = data >> (8 * step);
         end
         else
         begin
            push_piece(c.raw, dst, src, data[ODW-1:0], 1'b1);
            done = 1'b1;
         end
      end
   endtask

   task automatic compare_field(input string name, input logic [CW-1:0] exp,
                                input logic [CW-1:0] got);
      if (got !== exp)
      begin
         $display("error t=%0t %s exp %0h got %0h", $time, name, exp, got);
         errors++;
         test_errs++;
      end
   endtask

   task automatic check_beat();
      bit last;
      if (q_cmd.size() == 0)
      begin
         $display("unexpected output beat at %0t with no piece outstanding", $time);
         errors++;
      end
      else
      begin
         compare_field("umi_out_cmd", CW'(q_cmd.pop_front()), CW'(out_cmd));
         compare_field("umi_out_dstaddr", CW'(q_dst.pop_front()), CW'(out_dstaddr));
         compare_field("umi_out_srcaddr", CW'(q_src.pop_front()), CW'(out_srcaddr));
         compare_field("umi_out_data", CW'(q_data.pop_front()), CW'(out_data));
         last = q_last.pop_front();
         piece_n++;
         if (last)
         begin
            tests++;
            $display("test %0d: %s, %0d pieces", tests, (test_errs == 0) ? "ok" : "failed",
                     piece_n);
            test_errs = 0;
            piece_n   = 0;
         end
      end
   endtask

   // Push before compare so bypass beats find their piece
   always @(negedge umi_in_clk)
   begin
      if (in_valid && in_ready)
         expect_txn(in_cmd, in_dstaddr, in_srcaddr, in_data);
      if (out_valid && out_ready)
         check_beat();
      pending = q_cmd.size();
   end

   always @(posedge report)
      $display("summary: %0d transactions, %0d pieces, %0d checker errors, %0d testbench errors",
               tests, exp_pieces, errors, tb_errors);

endmodule

// ==== vlog.f ====
design/umi_pkg.sv
design/umi_flex_pkg.sv
design/umi_splitter.sv
design/umi_sync_fifo.sv
design/umi_flex_regs.sv
design/umi_fifo_flex.sv
dv/umi_flex_checker.sv
dv/tb_umi_fifo_flex.sv
